//--- Makefile
# Verilator flow for the fetch stage testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f build.f --top-module fetch_tb \
		-Mdir obj_dir -o fetch_sim

run: compile
	./obj_dir/fetch_sim | tee run.log
	grep -q "^all tests passed$$" run.log

clean:
	rm -rf obj_dir run.log

//--- build.f
+incdir+rtl
rtl/fetch_pkg.sv
rtl/cla_16b.sv
rtl/stall_mem.sv
rtl/fetch.sv
rtl/fetch_top.sv
testbench/clk_gen.sv
testbench/fetch_checker.sv
testbench/fetch_tb.sv

//--- rtl/cla_16b.sv
/*
    16-bit carry-lookahead adder
    Four 4-bit lookahead groups joined by a group carry unit
*/
`timescale 1ns/10ps

module cla_16b (
    input  fetch_pkg::addr_t a,
    input  fetch_pkg::addr_t b,
    input  logic             c_in,
    output fetch_pkg::addr_t sum,
    output logic             c_out
);

    logic [15:0] p, g;         // Per-bit propagate and generate
    wire  [15:0] carry;        // Carry into each bit
    wire  [3:0]  grp_p, grp_g; // Group propagate and generate
    logic [3:0]  gc;           // Carry into each group

    assign p = a ^ b;
    assign g = a & b;

    genvar gi;
    generate
        for (gi = 0; gi < 4; gi++) begin : g_grp
            logic [3:0] pp, gg;
            logic [3:0] cc;    // Carries inside the group

            assign pp = p[4*gi +: 4];
            assign gg = g[4*gi +: 4];

            assign cc[0] = gc[gi];
            assign cc[1] = gg[0] | (pp[0] & cc[0]);
            assign cc[2] = gg[1] | (pp[1] & gg[0]) | (pp[1] & pp[0] & cc[0]);
            assign cc[3] = gg[2] | (pp[2] & gg[1]) | (pp[2] & pp[1] & gg[0])
                         | (pp[2] & pp[1] & pp[0] & cc[0]);

            assign grp_p[gi] = &pp;                  // Whole group propagates
            assign grp_g[gi] = gg[3] | (pp[3] & gg[2]) | (pp[3] & pp[2] & gg[1])
                             | (pp[3] & pp[2] & pp[1] & gg[0]);

            assign carry[4*gi +: 4] = cc;
        end
    endgenerate

    // Second lookahead level
    assign gc[0] = c_in;
    assign gc[1] = grp_g[0] | (grp_p[0] & c_in);
    assign gc[2] = grp_g[1] | (grp_p[1] & grp_g[0]) | (grp_p[1] & grp_p[0] & c_in);
    assign gc[3] = grp_g[2] | (grp_p[2] & grp_g[1]) | (grp_p[2] & grp_p[1] & grp_g[0])
                 | (grp_p[2] & grp_p[1] & grp_p[0] & c_in);
    assign c_out = grp_g[3] | (grp_p[3] & grp_g[2]) | (grp_p[3] & grp_p[2] & grp_g[1])
                 | (grp_p[3] & grp_p[2] & grp_p[1] & grp_g[0])
                 | (grp_p[3] & grp_p[2] & grp_p[1] & grp_p[0] & c_in);

    assign sum = p ^ carry;    // Final sum bits

    // Both lookahead levels agree with a plain ripple add
    always_comb begin
        assert final ({c_out, sum} == 17'(a) + 17'(b) + 17'(c_in))
            else $error("cla_16b mismatch a=%h b=%h c_in=%b", a, b, c_in);
    end

endmodule

//--- rtl/fetch.sv
/*
    Instruction fetch stage
    PC register, branch select, PC+2 and hold logic for stalls and halts
*/
`timescale 1ns/10ps
`include "fetch_defines.svh"

module fetch (
    input  logic             clk,
    input  logic             rst_n,
    input  fetch_pkg::addr_t pc_b,        // Target back from execute
    input  logic             branch,
    input  logic             nop,
    input  logic             nop_branch,
    input  logic             halt,
    input  fetch_pkg::word_t data_out,    // Memory read word
    input  logic             done,        // Memory access complete
    input  logic             err,         // Memory alignment error
    output fetch_pkg::addr_t addr,
    output fetch_pkg::word_t instr,
    output fetch_pkg::addr_t pc_next,
    output fetch_pkg::addr_t pc_curr,
    output logic             fetch_stall,
    output logic             err_out
);

    fetch_pkg::addr_t pc;       // PC register
    fetch_pkg::addr_t pc_sum;   // pc_curr + 2
    logic             hold;     // Keep the PC this cycle

    // PC loads every edge, hold is done by the mux
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= '0;
        end else begin
            pc <= pc_next;
        end
    end

    assign pc_curr = branch ? pc_b : pc;   // Branch wins in the same cycle
    assign addr = pc_curr;

    // Sequential increment, carry out dropped so the PC wraps
    cla_16b pc_add2 (
        .a    (pc_curr),
        .b    (fetch_pkg::addr_t'(`PC_STEP)),
        .c_in (1'b0),
        .sum  (pc_sum),
        .c_out()
    );

    assign fetch_stall = ~done;
    assign hold = nop | nop_branch | halt | fetch_stall;
    assign pc_next = hold ? pc_curr : pc_sum;

    assign instr = data_out;    // Straight from memory
    assign err_out = err;

    // A stalled fetch retried from the same PC clears within three waits
    a_stall_bound: assert property (@(posedge clk) disable iff (!rst_n)
        (fetch_stall && !branch) [*3] |=> (!fetch_stall || branch))
        else $error("fetch stalled on %h beyond three wait cycles", pc);

endmodule

//--- rtl/fetch_defines.svh
/*
    Fetch stage constants
    Word width, PC step, instruction memory depth and latency field
*/
`ifndef FETCH_DEFINES_SVH
`define FETCH_DEFINES_SVH

// Word and byte address width
`define FETCH_WIDTH 16

// Bytes per instruction
`define PC_STEP 2

// Instruction memory depth in words, addresses wrap
`define IMEM_WORDS 256

// Low bit of the 2-bit extra latency field, addr[3:2]
`define LAT_LSB 2

`endif

//--- rtl/fetch_pkg.sv
/*
    Fetch package
    Word and address types plus the instruction memory content rule
*/
`include "fetch_defines.svh"

package fetch_pkg;

    typedef logic [`FETCH_WIDTH-1:0] word_t;   // Instruction word
    typedef logic [`FETCH_WIDTH-1:0] addr_t;   // Byte address

    // Content of the instruction word at a given word index
    function automatic word_t imem_word(input int unsigned idx);
        logic [31:0] prod;
        prod = idx * 32'h0000_9E37;           // Scramble the index
        return word_t'(prod[15:0] ^ 16'h0800);
    endfunction

endpackage

//--- rtl/fetch_top.sv
/*
    Fetch top level
    Fetch stage wired to the stalling instruction memory
*/
`timescale 1ns/10ps

module fetch_top (
    input  logic             clk,
    input  logic             rst_n,
    input  fetch_pkg::addr_t pc_b,
    input  logic             branch,
    input  logic             nop,
    input  logic             nop_branch,
    input  logic             halt,
    output fetch_pkg::word_t instr,
    output fetch_pkg::addr_t pc_curr,
    output fetch_pkg::addr_t pc_next,
    output logic             fetch_stall,
    output logic             err
);

    fetch_pkg::addr_t imem_addr;   // PC into memory
    fetch_pkg::word_t imem_data;
    logic             imem_done;
    logic             imem_err;

    fetch u_fetch (
        .clk        (clk),
        .rst_n      (rst_n),
        .pc_b       (pc_b),
        .branch     (branch),
        .nop        (nop),
        .nop_branch (nop_branch),
        .halt       (halt),
        .data_out   (imem_data),
        .done       (imem_done),
        .err        (imem_err),
        .addr       (imem_addr),
        .instr      (instr),
        .pc_next    (pc_next),
        .pc_curr    (pc_curr),
        .fetch_stall(fetch_stall),
        .err_out    (err)
    );

    stall_mem u_imem (
        .clk     (clk),
        .rst_n   (rst_n),
        .addr    (imem_addr),
        .data_out(imem_data),
        .done    (imem_done),
        .err     (imem_err)
    );

endmodule

//--- rtl/stall_mem.sv
/*
    Read-only instruction memory with address-dependent latency
    Done level closes each access, odd addresses flag an error
*/
`timescale 1ns/10ps
`include "fetch_defines.svh"

module stall_mem (
    input  logic             clk,
    input  logic             rst_n,
    input  fetch_pkg::addr_t addr,
    output fetch_pkg::word_t data_out,
    output logic             done,
    output logic             err
);

    localparam int IDX_W = $clog2(`IMEM_WORDS);   // Word index bits

    fetch_pkg::word_t mem [`IMEM_WORDS];          // Instruction contents

    fetch_pkg::addr_t srv_addr;   // Address being served
    logic             srv_vld;    // Served address is meaningful
    logic [1:0]       cnt;        // Remaining wait cycles
    logic [1:0]       lat;        // Latency field of the current address
    logic             hit;        // Same access as last cycle
    logic [1:0]       cnt_eff;    // Countdown seen this cycle
    logic [IDX_W-1:0] idx;

    assign lat = addr[`LAT_LSB+1:`LAT_LSB];
    assign hit = srv_vld && (addr == srv_addr);
    assign cnt_eff = hit ? cnt : lat;   // New address restarts the count

    assign done = (cnt_eff == 2'd0);    // Latency 0 completes at once
    assign idx = addr[IDX_W:1];         // Byte to word, wraps at depth
    assign data_out = done ? mem[idx] : '0;
    assign err = addr[0];               // Misaligned fetch

    // Load the fixed contents while in reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `IMEM_WORDS; i++) begin
                mem[i] <= fetch_pkg::imem_word(i);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            srv_addr <= '0;
            srv_vld  <= 1'b0;                      // Force a fresh access
            cnt      <= 2'd0;
        end else begin
            srv_addr <= addr;
            srv_vld  <= 1'b1;
            cnt      <= done ? 2'd0 : cnt_eff - 2'd1;   // Saturate at zero
        end
    end

    // Any address held for 4 cycles has completed
    a_lat_bound: assert property (@(posedge clk) disable iff (!rst_n)
        hit [*3] |-> done)
        else $error("stall_mem access on %h exceeded 3 wait cycles", addr);

    // A held access never counts past its own latency field
    a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
        hit |-> (cnt < lat || cnt == 2'd0))
        else $error("stall_mem countdown wrapped");

endmodule

//--- testbench/clk_gen.sv
/*
    Testbench clock and reset
    20 ns clock, active-low reset held for two rising edges
*/
`timescale 1ns/10ps

module clk_gen (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;   // 20 ns period
    end

    initial begin
        rst_n = 1'b0;
        repeat (2) @(posedge clk);
        #2 rst_n = 1'b1;          // Released off the edge like other inputs
    end

endmodule

//--- testbench/fetch_checker.sv
/*
    Fetch checker
    Reference model of PC flow, memory latency and instruction contents
*/
`timescale 1ns/10ps

module fetch_checker (
    input logic             clk,
    input logic             rst_n,
    input fetch_pkg::addr_t pc_b,
    input logic             branch,
    input logic             nop,
    input logic             nop_branch,
    input logic             halt,
    input fetch_pkg::word_t instr,
    input fetch_pkg::addr_t pc_curr,
    input fetch_pkg::addr_t pc_next,
    input logic             fetch_stall,
    input logic             err
);

    string       test_name = "reset";
    int          test_checks = 0;
    int          test_errs = 0;
    int          tests_run = 0;
    int          tests_clean = 0;
    int          check_total = 0;
    int          err_total = 0;   // Read by the testbench top
    logic        prev_live = 1'b0; // Last sample was out of reset
    logic [15:0] prev_next;        // pc_next seen before the edge
    logic [15:0] last_addr;        // Address of the previous sample
    int          waited = 0;       // Cycles spent on the same address

    // Word at addr[8:1], index times 9E37 then XOR 0800
    function automatic logic [15:0] exp_instr(input logic [15:0] a);
        logic [15:0] idx;
        idx = {8'h00, a[8:1]};
        return (idx * 16'h9E37) ^ 16'h0800;
    endfunction

    // Extra wait cycles come from addr[3:2]
    function automatic int lat_field(input logic [15:0] a);
        return int'(a[3:2]);
    endfunction

    task automatic compare_value(input string what, input logic [15:0] exp,
                                 input logic [15:0] act);
        test_checks++;
        check_total++;
        if (act !== exp) begin
            test_errs++;
            err_total++;
            $display("[FAIL] %s: %s expected %h actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        test_checks = 0;
        test_errs = 0;
    endtask

    task automatic end_test();
        tests_run++;
        if (test_errs == 0) begin
            tests_clean++;
            $display("test %s: ok, %0d checks", test_name, test_checks);
        end else begin
            $display("test %s: %0d of %0d checks wrong", test_name, test_errs, test_checks);
        end
    endtask

    task automatic report();
        $display("Summary: %0d tests run, %0d clean, %0d checks, %0d errors",
                 tests_run, tests_clean, check_total, err_total);
    endtask

    // Sample mid-cycle, inputs and outputs are settled
    always @(negedge clk) begin
        logic        stall_exp;
        logic [15:0] next_exp;
        if (rst_n) begin
            if (!prev_live || pc_curr != last_addr) waited = 0;   // Fresh access
            else waited = waited + 1;
            stall_exp = (waited < lat_field(pc_curr));

            if (branch) compare_value("branch pc", pc_b, pc_curr);   // Same-cycle select
            else if (prev_live) compare_value("pc", prev_next, pc_curr);
            else compare_value("reset pc", 16'h0000, pc_curr);

            compare_value("fetch_stall", 16'(stall_exp), 16'(fetch_stall));
            next_exp = (nop | nop_branch | halt | stall_exp) ? pc_curr : pc_curr + 16'd2;
            compare_value("pc_next", next_exp, pc_next);
            compare_value("err", 16'(pc_curr[0]), 16'(err));   // Odd address flag
            if (!fetch_stall) compare_value("instr", exp_instr(pc_curr), instr);

            prev_next = pc_next;
            last_addr = pc_curr;
            prev_live = 1'b1;
        end else begin
            prev_live = 1'b0;   // Memory drops its served address in reset
        end
    end

endmodule

//--- testbench/fetch_tb.sv
/*
    Fetch stage testbench
    Drives fetch_top through its phases, watchdog and final verdict
*/
`timescale 1ns/10ps

module fetch_tb;

    localparam int N_SEQ = 24;    // Fetches with all controls low
    localparam int N_STALL = 8;   // Fetches from a latency-3 start
    localparam int N_HOLD = 40;   // Random hold cycles
    localparam int N_BR = 8;      // Branches, two fetches each
    localparam int N_MIS = 3;     // Odd branches, three fetches each
    localparam int FETCHES = N_SEQ + N_STALL + 2 * N_BR + 3 * N_MIS;
    localparam int PHASE_CYC = 4 + N_HOLD + FETCHES;
    localparam int LIMIT_NS = (PHASE_CYC + 4 * FETCHES) * 20;

    logic             clk;
    logic             rst_n;
    fetch_pkg::addr_t pc_b;
    logic             branch;
    logic             nop;
    logic             nop_branch;
    logic             halt;
    fetch_pkg::word_t instr;
    fetch_pkg::addr_t pc_curr;
    fetch_pkg::addr_t pc_next;
    logic             fetch_stall;
    logic             err;
    integer           seed;
    logic [31:0]      r;

    clk_gen u_clk (.clk(clk), .rst_n(rst_n));

    fetch_top i_dut (
        .clk(clk), .rst_n(rst_n), .pc_b(pc_b), .branch(branch), .nop(nop),
        .nop_branch(nop_branch), .halt(halt), .instr(instr), .pc_curr(pc_curr),
        .pc_next(pc_next), .fetch_stall(fetch_stall), .err(err)
    );

    fetch_checker u_chk (
        .clk(clk), .rst_n(rst_n), .pc_b(pc_b), .branch(branch), .nop(nop),
        .nop_branch(nop_branch), .halt(halt), .instr(instr), .pc_curr(pc_curr),
        .pc_next(pc_next), .fetch_stall(fetch_stall), .err(err)
    );

    task automatic next_cycle();
        @(posedge clk);
        #2;   // Drive point
    endtask

    // Count completed fetches, seen mid-cycle
    task automatic run_fetches(input int n);
        int got;
        got = 0;
        while (got < n) begin
            @(negedge clk);
            if (!fetch_stall) got++;
            next_cycle();
        end
    endtask

    // Branch held until its fetch completes
    task automatic issue_branch(input logic [15:0] target);
        pc_b = target;
        branch = 1'b1;
        run_fetches(1);
        branch = 1'b0;
    endtask

    initial begin
        seed = 32'h15ad;
        pc_b = '0;
        branch = 1'b0;
        nop = 1'b0;
        nop_branch = 1'b0;
        halt = 1'b0;
        u_chk.begin_test("sequential");
        @(posedge rst_n);
        run_fetches(N_SEQ);
        u_chk.end_test();

        u_chk.begin_test("stall");
        issue_branch(16'h002C);   // Latency field 3
        run_fetches(N_STALL - 1);
        u_chk.end_test();

        u_chk.begin_test("hold");
        for (int i = 0; i < N_HOLD; i++) begin
            r = $random(seed);
            nop = (r[1:0] == 2'd1);
            nop_branch = (r[1:0] == 2'd2);
            halt = (r[1:0] == 2'd3);   // Zero leaves the PC free
            next_cycle();
        end
        nop = 1'b0;
        nop_branch = 1'b0;
        halt = 1'b0;
        u_chk.end_test();

        u_chk.begin_test("branch");
        for (int i = 0; i < N_BR; i++) begin
            r = $random(seed);
            issue_branch({r[15:1], 1'b0});
            run_fetches(1);   // Lands on target + 2
        end
        u_chk.end_test();

        u_chk.begin_test("misaligned");
        for (int i = 0; i < N_MIS; i++) begin
            r = $random(seed);
            issue_branch({r[15:1], 1'b1});
            run_fetches(2);
        end
        u_chk.end_test();

        u_chk.report();
        if (u_chk.err_total == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    // Watchdog sized from the phase lengths
    initial begin
        #(LIMIT_NS);
        $display("Timeout: the run did not finish within %0d ns", LIMIT_NS);
        $display("tests failed");
        $finish;
    end

endmodule
